// File: logic/spi_csr_pkg.sv
// register bus widths, address and data types, access and arbiter enums, register constants.
package spi_csr_pkg;

    localparam int csr_addr_w = 5;    // 32 registers.
    localparam int csr_data_w = 8;    // one byte per register.

    localparam int spi_port_count = 2;

    typedef logic [csr_addr_w-1:0] csr_addr_t;
    typedef logic [csr_data_w-1:0] csr_data_t;

    // register 0 reads back a fixed identification byte.
    localparam csr_addr_t csr_id_addr  = '0;
    localparam csr_data_t csr_id_value = 8'hc5;

    // kind of access waiting in a port slot.
    typedef enum logic [1:0] {
        csr_op_none,
        csr_op_read,
        csr_op_write
    } csr_op_t;

    // the arbiter serves one access at a time onto the bank bus.
    typedef enum logic [1:0] {
        arb_idle,
        arb_write,
        arb_read,
        arb_read_return
    } arb_state_t;

endpackage

// File: logic/csr_port_if.sv
// interface for one register access path, with initiator and target modports.
`timescale 1ns/1ps

interface csr_port_if;

    spi_csr_pkg::csr_addr_t address;
    logic                   read;       // single clk pulse.
    logic                   write;      // single clk pulse.
    spi_csr_pkg::csr_data_t writedata;
    spi_csr_pkg::csr_data_t readdata;

    // the side that issues accesses.
    modport initiator (
        output address,
        output read,
        output write,
        output writedata,
        input  readdata
    );

    // the side that answers them.
    modport target (
        input  address,
        input  read,
        input  write,
        input  writedata,
        output readdata
    );

endinterface

// File: logic/cdc_event.sv
// pulse synchronizer that carries single-cycle events across clock domains by toggle.
`timescale 1ns/1ps

module cdc_event (
    input  logic src_clk,
    input  logic src_reset_n,
    input  logic src_event,
    input  logic clk,
    input  logic spi_reset_n,
    output logic dst_event
);

    logic       src_toggle;
    logic [2:0] dst_sync;    // two synchronizer stages plus the previous value.

    always_ff @(posedge src_clk or negedge src_reset_n) begin
        if (!src_reset_n) begin
            src_toggle <= 1'b0;
        end else if (src_event) begin
            src_toggle <= ~src_toggle;    // every source pulse flips the level.
        end
    end

    // a change of the synchronized level becomes one clk pulse.
    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            dst_sync  <= 3'b000;
            dst_event <= 1'b0;
        end else begin
            dst_sync  <= {dst_sync[1:0], src_toggle};
            dst_event <= dst_sync[2] ^ dst_sync[1];
        end
    end

endmodule

// File: logic/spi_slave.sv
// SPI slave shift engine with command decode, transmit shifter and CSR pulse generation.
`timescale 1ns/1ps

module spi_slave (
    input  logic clk,
    input  logic spi_reset_n,
    input  logic sck,
    input  logic nss_n,
    input  logic sdi,
    output logic sdo,
    output logic sdo_en,
    output logic chip_select_n,
    csr_port_if.initiator csr
);

    logic [1:0]             nss_sync;
    logic                   frame_reset_n;
    logic [2:0]             bit_cnt;
    logic [7:0]             rx_shift;
    logic [7:0]             tx_shift;
    logic                   is_first_byte;
    logic                   is_write;
    logic                   write_event;
    logic                   read_event;
    spi_csr_pkg::csr_addr_t address_q;
    spi_csr_pkg::csr_data_t writedata_q;

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            nss_sync <= 2'b11;
        end else begin
            nss_sync <= {nss_sync[0], nss_n};
        end
    end

    assign chip_select_n = nss_sync[1];

    // the frame logic is held in reset whenever the master deselects us.
    assign frame_reset_n = spi_reset_n & ~nss_n;
    assign sdo_en        = frame_reset_n;
    assign sdo           = tx_shift[7];

    // receive side runs on rising sck; events are raised one edge early
    // so that the toggle in cdc_event flips on the last bit of the byte.
    always_ff @(posedge sck or negedge frame_reset_n) begin
        if (!frame_reset_n) begin
            bit_cnt       <= 3'd0;
            rx_shift      <= 8'h00;
            is_first_byte <= 1'b1;
            is_write      <= 1'b0;
            write_event   <= 1'b0;
            read_event    <= 1'b0;
        end else begin
            write_event <= 1'b0;
            read_event  <= 1'b0;
            rx_shift    <= {rx_shift[6:0], sdi};
            bit_cnt     <= bit_cnt + 3'd1;

            if (bit_cnt == 3'd6) begin
                if (is_first_byte) begin
                    read_event <= ~rx_shift[5];    // rx_shift[5] is the write flag here.
                end else begin
                    write_event <= is_write;
                    read_event  <= ~is_write;      // refetch the same register.
                end
            end

            if (bit_cnt == 3'd7) begin
                is_first_byte <= 1'b0;
                if (is_first_byte) begin
                    is_write <= rx_shift[6];
                end
            end
        end
    end

    // address and data only change on byte boundaries and stay put while
    // the clk side samples them after the pulse crosses over.
    always_ff @(posedge sck) begin
        if (bit_cnt == 3'd7) begin
            if (is_first_byte) begin
                address_q <= {rx_shift[spi_csr_pkg::csr_addr_w-2:0], sdi};
            end else begin
                writedata_q <= {rx_shift[6:0], sdi};
            end
        end
    end

    assign csr.address   = address_q;
    assign csr.writedata = writedata_q;

    // transmit side on falling sck; a new byte is loaded at each byte boundary.
    always_ff @(negedge sck or negedge frame_reset_n) begin
        if (!frame_reset_n) begin
            tx_shift <= 8'h00;
        end else if (bit_cnt == 3'd0) begin
            tx_shift <= csr.readdata;
        end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
        end
    end

    cdc_event write_cdc (
        .src_clk     (sck),
        .src_reset_n (frame_reset_n),
        .src_event   (write_event),
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .dst_event   (csr.write)
    );

    cdc_event read_cdc (
        .src_clk     (sck),
        .src_reset_n (frame_reset_n),
        .src_event   (read_event),
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .dst_event   (csr.read)
    );

endmodule

// File: logic/csr_arbiter.sv
// round-robin arbiter with one pending slot per SPI port in front of the register bank.
`timescale 1ns/1ps

module csr_arbiter (
    input  logic clk,
    input  logic spi_reset_n,
    csr_port_if.target    port0,
    csr_port_if.target    port1,
    csr_port_if.initiator bank
);

    typedef logic [$clog2(spi_csr_pkg::spi_port_count)-1:0] port_idx_t;

    spi_csr_pkg::arb_state_t state;
    spi_csr_pkg::csr_op_t    pend_op    [spi_csr_pkg::spi_port_count];
    spi_csr_pkg::csr_addr_t  pend_addr  [spi_csr_pkg::spi_port_count];
    spi_csr_pkg::csr_data_t  pend_data  [spi_csr_pkg::spi_port_count];
    spi_csr_pkg::csr_data_t  port_rdata [spi_csr_pkg::spi_port_count];
    logic                    port_rd    [spi_csr_pkg::spi_port_count];
    logic                    port_wr    [spi_csr_pkg::spi_port_count];
    spi_csr_pkg::csr_addr_t  port_addr  [spi_csr_pkg::spi_port_count];
    spi_csr_pkg::csr_data_t  port_wdata [spi_csr_pkg::spi_port_count];
    port_idx_t               last_served;
    port_idx_t               cur_port;
    port_idx_t               grant_idx;
    logic                    grant_valid;
    spi_csr_pkg::csr_addr_t  cur_addr;
    spi_csr_pkg::csr_data_t  cur_data;

    assign port_rd[0]    = port0.read;
    assign port_wr[0]    = port0.write;
    assign port_addr[0]  = port0.address;
    assign port_wdata[0] = port0.writedata;
    assign port0.readdata = port_rdata[0];
    assign port_rd[1]    = port1.read;
    assign port_wr[1]    = port1.write;
    assign port_addr[1]  = port1.address;
    assign port_wdata[1] = port1.writedata;
    assign port1.readdata = port_rdata[1];

    // search starts just after the port served last.
    always_comb begin
        port_idx_t idx;
        grant_valid = 1'b0;
        grant_idx   = last_served;
        for (int i = 1; i <= spi_csr_pkg::spi_port_count; i++) begin
            idx = port_idx_t'((int'(last_served) + i) % spi_csr_pkg::spi_port_count);
            if (!grant_valid && pend_op[idx] != spi_csr_pkg::csr_op_none) begin
                grant_valid = 1'b1;
                grant_idx   = idx;
            end
        end
    end

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            state       <= spi_csr_pkg::arb_idle;
            last_served <= '0;
            cur_port    <= '0;
            for (int p = 0; p < spi_csr_pkg::spi_port_count; p++) begin
                pend_op[p]    <= spi_csr_pkg::csr_op_none;
                port_rdata[p] <= '0;
            end
        end else begin
            for (int p = 0; p < spi_csr_pkg::spi_port_count; p++) begin
                if (port_wr[p]) begin
                    pend_op[p] <= spi_csr_pkg::csr_op_write;
                end else if (port_rd[p]) begin
                    pend_op[p] <= spi_csr_pkg::csr_op_read;
                end else if (state == spi_csr_pkg::arb_idle && grant_valid &&
                             int'(grant_idx) == p) begin
                    pend_op[p] <= spi_csr_pkg::csr_op_none;    // slot taken for service.
                end
            end
            case (state)
                spi_csr_pkg::arb_idle: begin
                    if (grant_valid) begin
                        cur_port    <= grant_idx;
                        last_served <= grant_idx;
                        state <= (pend_op[grant_idx] == spi_csr_pkg::csr_op_write) ?
                                 spi_csr_pkg::arb_write : spi_csr_pkg::arb_read;
                    end
                end
                spi_csr_pkg::arb_read:        state <= spi_csr_pkg::arb_read_return;
                spi_csr_pkg::arb_read_return: begin
                    port_rdata[cur_port] <= bank.readdata;    // bank data is registered.
                    state <= spi_csr_pkg::arb_idle;
                end
                default: state <= spi_csr_pkg::arb_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < spi_csr_pkg::spi_port_count; p++) begin
            if (port_wr[p] || port_rd[p]) begin
                pend_addr[p] <= port_addr[p];
                pend_data[p] <= port_wdata[p];
            end
        end
        if (state == spi_csr_pkg::arb_idle && grant_valid) begin
            cur_addr <= pend_addr[grant_idx];
            cur_data <= pend_data[grant_idx];
        end
    end

    assign bank.address   = cur_addr;
    assign bank.writedata = cur_data;
    assign bank.write     = (state == spi_csr_pkg::arb_write);
    assign bank.read      = (state == spi_csr_pkg::arb_read);

endmodule

// File: logic/csr_regfile.sv
// 32-byte control/status register bank with a fixed identification register.
`timescale 1ns/1ps

module csr_regfile (
    input  logic clk,
    input  logic spi_reset_n,
    csr_port_if.target bus
);

    localparam int reg_count = 2 ** spi_csr_pkg::csr_addr_w;

    spi_csr_pkg::csr_data_t regs [reg_count];

    always_ff @(posedge clk or negedge spi_reset_n) begin
        if (!spi_reset_n) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.write && bus.address != spi_csr_pkg::csr_id_addr) begin
            regs[bus.address] <= bus.writedata;    // the id register ignores writes.
        end
    end

    // one cycle read latency.
    always_ff @(posedge clk) begin
        if (bus.read) begin
            if (bus.address == spi_csr_pkg::csr_id_addr) begin
                bus.readdata <= spi_csr_pkg::csr_id_value;
            end else begin
                bus.readdata <= regs[bus.address];
            end
        end
    end

endmodule

// File: logic/dual_spi_csr_top.sv
// top level with two SPI slave ports sharing one register bank through an arbiter.
`timescale 1ns/1ps

module dual_spi_csr_top (
    input  logic clk,
    input  logic spi_reset_n,
    input  logic sck0,
    input  logic nss0_n,
    input  logic sdi0,
    output logic sdo0,
    output logic sdo0_en,
    output logic chip_select0_n,
    input  logic sck1,
    input  logic nss1_n,
    input  logic sdi1,
    output logic sdo1,
    output logic sdo1_en,
    output logic chip_select1_n
);

    csr_port_if port0_bus ();
    csr_port_if port1_bus ();
    csr_port_if bank_bus ();

    spi_slave port0_slave (
        .clk           (clk),
        .spi_reset_n   (spi_reset_n),
        .sck           (sck0),
        .nss_n         (nss0_n),
        .sdi           (sdi0),
        .sdo           (sdo0),
        .sdo_en        (sdo0_en),
        .chip_select_n (chip_select0_n),
        .csr           (port0_bus.initiator)
    );

    spi_slave port1_slave (
        .clk           (clk),
        .spi_reset_n   (spi_reset_n),
        .sck           (sck1),
        .nss_n         (nss1_n),
        .sdi           (sdi1),
        .sdo           (sdo1),
        .sdo_en        (sdo1_en),
        .chip_select_n (chip_select1_n),
        .csr           (port1_bus.initiator)
    );

    csr_arbiter arbiter (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .port0       (port0_bus.target),
        .port1       (port1_bus.target),
        .bank        (bank_bus.initiator)
    );

    csr_regfile regfile (
        .clk         (clk),
        .spi_reset_n (spi_reset_n),
        .bus         (bank_bus.target)
    );

endmodule

// File: testbench/tb_dual_spi_csr.sv
// testbench for the dual-port SPI register block with bit-bang SPI masters and a register model.
`timescale 1ns/1ps

module tb_dual_spi_csr;

    typedef spi_csr_pkg::csr_data_t frame_t [4];

    logic       clk;
    logic       spi_reset_n;
    logic [1:0] sck;
    logic [1:0] nss_n;
    logic [1:0] sdi;
    wire  [1:0] sdo;
    wire  [1:0] sdo_en;
    wire  [1:0] cs_n;

    spi_csr_pkg::csr_data_t model [32];    // mirror of the register bank.
    int error_count;
    int tests_passed;
    int tests_failed;

    dual_spi_csr_top uut (
        .clk            (clk),
        .spi_reset_n    (spi_reset_n),
        .sck0           (sck[0]),
        .nss0_n         (nss_n[0]),
        .sdi0           (sdi[0]),
        .sdo0           (sdo[0]),
        .sdo0_en        (sdo_en[0]),
        .chip_select0_n (cs_n[0]),
        .sck1           (sck[1]),
        .nss1_n         (nss_n[1]),
        .sdi1           (sdi[1]),
        .sdo1           (sdo[1]),
        .sdo1_en        (sdo_en[1]),
        .chip_select1_n (cs_n[1])
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_data(input spi_csr_pkg::csr_data_t got,
                              input spi_csr_pkg::csr_data_t exp, input string message);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got 8'h%02h, expected 8'h%02h",
                     $time, message, got, exp);
            error_count++;
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string message);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, message, got, exp);
            error_count++;
        end
    endtask

    // address 0 is the fixed id byte and the rest are plain storage.
    function automatic void mirror_write(input spi_csr_pkg::csr_addr_t addr,
                                         input spi_csr_pkg::csr_data_t data);
        if (addr != 5'd0) begin
            model[addr] = data;
        end
    endfunction

    function automatic spi_csr_pkg::csr_data_t expected_value(input spi_csr_pkg::csr_addr_t addr);
        if (addr == 5'd0) begin
            return spi_csr_pkg::csr_id_value;
        end
        return model[addr];
    endfunction

    function automatic spi_csr_pkg::csr_data_t command_byte(input spi_csr_pkg::csr_op_t op,
                                                            input spi_csr_pkg::csr_addr_t addr);
        return {op == spi_csr_pkg::csr_op_write, 2'b00, addr};
    endfunction

    function automatic spi_csr_pkg::csr_addr_t random_addr();
        return spi_csr_pkg::csr_addr_t'($urandom_range(30) + 1);    // never the id register.
    endfunction

    task automatic half_period();
        repeat (20) @(posedge clk);
        #10;
    endtask

    task automatic await_chip_select(input int port, input logic level);
        int cycles;
        cycles = 0;
        while ((cs_n[port] !== level || sdo_en[port] !== ~level) && cycles < 20) begin
            @(posedge clk);
            #10;
            cycles++;
        end
        if (cs_n[port] !== level || sdo_en[port] !== ~level) begin
            $display("timeout: port %0d chip select did not follow nss_n within 20 clk cycles",
                     port);
            error_count++;
        end
    endtask

    // mode 0 master that changes sdi on falling sck and takes sdo at each rising edge.
    task automatic spi_transfer(input int port, input int count, input frame_t tx,
                                output frame_t rx);
        rx = '{default: 8'h00};
        @(posedge clk);
        #10;
        nss_n[port] = 1'b0;
        sdi[port]   = tx[0][7];
        for (int b = 0; b < count; b++) begin
            for (int i = 7; i >= 0; i--) begin
                half_period();
                rx[b][i]  = sdo[port];
                sck[port] = 1'b1;
                half_period();
                sck[port] = 1'b0;
                if (i > 0) begin
                    sdi[port] = tx[b][i-1];
                end else if (b + 1 < count) begin
                    sdi[port] = tx[b+1][7];
                end
            end
        end
        half_period();
        nss_n[port] = 1'b1;
        await_chip_select(port, 1'b1);
    endtask

    task automatic log_result(input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("%s: ok", name);
            tests_passed++;
        end else begin
            $display("%s: failed", name);
            tests_failed++;
        end
    endtask

    task automatic chip_select_idle_and_active();
        int errs_before;
        errs_before = error_count;
        for (int p = 0; p < 2; p++) begin
            check_level(cs_n[p], 1'b1, $sformatf("port %0d chip select while idle", p));
            check_level(sdo_en[p], 1'b0, $sformatf("port %0d sdo_en while idle", p));
        end
        for (int p = 0; p < 2; p++) begin
            @(posedge clk);
            #10;
            nss_n[p] = 1'b0;
            await_chip_select(p, 1'b0);
            check_level(cs_n[1-p], 1'b1, "chip select of the other port");
            check_level(sdo_en[1-p], 1'b0, "sdo_en of the other port");
            nss_n[p] = 1'b1;
            await_chip_select(p, 1'b1);
        end
        log_result("chip select", errs_before);
    endtask

    task automatic write_then_read();
        int errs_before;
        spi_csr_pkg::csr_addr_t addr;
        spi_csr_pkg::csr_data_t data;
        frame_t rx;
        errs_before = error_count;
        addr = random_addr();
        data = spi_csr_pkg::csr_data_t'($urandom);
        spi_transfer(0, 2, '{command_byte(spi_csr_pkg::csr_op_write, addr), data, 0, 0}, rx);
        mirror_write(addr, data);
        spi_transfer(0, 2, '{command_byte(spi_csr_pkg::csr_op_read, addr), 0, 0, 0}, rx);
        check_data(rx[1], expected_value(addr),
                   $sformatf("port 0 readback of register %0d", addr));
        log_result("write then read on port 0", errs_before);
    endtask

    task automatic shared_bank_access();
        int errs_before;
        spi_csr_pkg::csr_addr_t addr;
        spi_csr_pkg::csr_data_t data;
        frame_t rx;
        errs_before = error_count;
        for (int w = 1; w >= 0; w--) begin    // port 1 writes first, then port 0.
            addr = random_addr();
            data = spi_csr_pkg::csr_data_t'($urandom);
            spi_transfer(w, 2, '{command_byte(spi_csr_pkg::csr_op_write, addr), data, 0, 0}, rx);
            mirror_write(addr, data);
            spi_transfer(1 - w, 2, '{command_byte(spi_csr_pkg::csr_op_read, addr), 0, 0, 0}, rx);
            check_data(rx[1], expected_value(addr),
                       $sformatf("port %0d read of a value written by port %0d", 1 - w, w));
        end
        log_result("shared bank", errs_before);
    endtask

    task automatic id_register_readonly();
        int errs_before;
        frame_t rx;
        errs_before = error_count;
        spi_transfer(0, 2, '{command_byte(spi_csr_pkg::csr_op_read, 5'd0), 0, 0, 0}, rx);
        check_data(rx[1], expected_value(5'd0), "id register read");
        spi_transfer(0, 2, '{command_byte(spi_csr_pkg::csr_op_write, 5'd0),
                             spi_csr_pkg::csr_data_t'($urandom), 0, 0}, rx);
        spi_transfer(0, 2, '{command_byte(spi_csr_pkg::csr_op_read, 5'd0), 0, 0, 0}, rx);
        check_data(rx[1], expected_value(5'd0), "id register read after a write");
        log_result("identification register", errs_before);
    endtask

    task automatic concurrent_ports();
        int errs_before;
        spi_csr_pkg::csr_addr_t addr0;
        spi_csr_pkg::csr_addr_t addr1;
        spi_csr_pkg::csr_data_t data0;
        spi_csr_pkg::csr_data_t data1;
        frame_t rx0;
        frame_t rx1;
        errs_before = error_count;
        addr0 = random_addr();
        addr1 = spi_csr_pkg::csr_addr_t'(addr0 % 31 + 1);    // differs from addr0.
        data0 = spi_csr_pkg::csr_data_t'($urandom);
        data1 = ~data0;
        fork
            spi_transfer(0, 2, '{command_byte(spi_csr_pkg::csr_op_write, addr0), data0, 0, 0},
                         rx0);
            spi_transfer(1, 2, '{command_byte(spi_csr_pkg::csr_op_write, addr1), data1, 0, 0},
                         rx1);
        join
        mirror_write(addr0, data0);
        mirror_write(addr1, data1);
        fork
            spi_transfer(0, 2, '{command_byte(spi_csr_pkg::csr_op_read, addr0), 0, 0, 0}, rx0);
            spi_transfer(1, 2, '{command_byte(spi_csr_pkg::csr_op_read, addr1), 0, 0, 0}, rx1);
        join
        check_data(rx0[1], expected_value(addr0), "port 0 readback under contention");
        check_data(rx1[1], expected_value(addr1), "port 1 readback under contention");
        log_result("contention", errs_before);
    endtask

    task automatic multi_byte_frames();
        int errs_before;
        spi_csr_pkg::csr_addr_t addr;
        frame_t tx;
        frame_t rx;
        errs_before = error_count;
        addr = random_addr();
        tx[0] = command_byte(spi_csr_pkg::csr_op_write, addr);
        for (int b = 1; b < 4; b++) begin
            tx[b] = spi_csr_pkg::csr_data_t'($urandom);
            mirror_write(addr, tx[b]);    // each data byte overwrites the register.
        end
        spi_transfer(1, 4, tx, rx);
        spi_transfer(1, 4, '{command_byte(spi_csr_pkg::csr_op_read, addr), 0, 0, 0}, rx);
        for (int b = 1; b < 4; b++) begin
            check_data(rx[b], expected_value(addr), $sformatf("read frame byte %0d", b));
        end
        log_result("multi-byte frames", errs_before);
    endtask

    initial begin
        void'($urandom(32'h0e7d83bc));
        error_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < 32; i++) begin
            model[i] = 8'h00;
        end
        spi_reset_n = 1'b0;
        sck         = 2'b00;
        nss_n       = 2'b11;
        sdi         = 2'b00;
        repeat (10) @(posedge clk);
        #10;
        spi_reset_n = 1'b1;

        chip_select_idle_and_active();
        write_then_read();
        shared_bank_access();
        id_register_readonly();
        concurrent_ports();
        multi_byte_frames();

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/spi_csr_pkg.sv
logic/csr_port_if.sv
logic/cdc_event.sv
logic/spi_slave.sv
logic/csr_arbiter.sv
logic/csr_regfile.sv
logic/dual_spi_csr_top.sv
testbench/tb_dual_spi_csr.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dual_spi_csr
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TB PASSED$$'

clean:
	rm -rf $(BUILD_DIR)
